// ==== src/spi_reg_pkg.sv ====
// SPI register bank definitions
`default_nettype none

package spi_reg_pkg;

  // Frame geometry
  localparam int FRAME_BITS  = 64;
  localparam int FRAME_BYTES = 8;

  // Command opcodes, first byte on the wire
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;

  // Error flag position inside the status byte
  localparam int STATUS_ERR_BIT = 0;

  // Frame layout, top bit down
  // Opcode sits in the low byte since bytes arrive LSB first
  typedef struct packed {
    logic [31:0] data;
    logic [7:0]  pad;
    logic [7:0]  status;
    logic [7:0]  addr;
    logic [7:0]  opcode;
  } spi_frame_t;

  // Same 64 bits seen as a plain word or as decoded fields
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    spi_frame_t            fields;
  } spi_frame_u;

endpackage

`default_nettype wire

// ==== src/spi_pin_sync.sv ====
// SPI pin synchronizer
`timescale 1ns/10ps
`default_nettype none

module spi_pin_sync (
  input  logic clk,
  input  logic resetn,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic sck_rise,
  output logic sck_fall,
  output logic sel,
  output logic copi_s
);

  // Two sync stages, SCK carries a third for edge detection
  logic [2:0] sck_q;
  logic [1:0] cs_q;
  logic [1:0] copi_q;

  always_ff @(posedge clk) begin
    if (resetn) begin
      sck_q    <= '0;
      // Chip select idles deasserted
      cs_q     <= '1;
      copi_q   <= '0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_q    <= {sck_q[1:0], sck};
      cs_q     <= {cs_q[0], cs_n};
      copi_q   <= {copi_q[0], copi};
      // Registered strobes, three cycles after the pin edge
      sck_rise <= sck_q[1] & ~sck_q[2];
      sck_fall <= ~sck_q[1] & sck_q[2];
    end
  end

  assign sel    = ~cs_q[1];
  assign copi_s = copi_q[1];

  // Edge strobes are mutually exclusive
  a_edge_excl: assert property (@(posedge clk) disable iff (resetn)
    !(sck_rise && sck_fall));

endmodule

`default_nettype wire

// ==== src/spi_byte_link.sv ====
// SPI mode 0 byte shifter
`timescale 1ns/10ps
`default_nettype none

module spi_byte_link (
  input  logic       clk,
  input  logic       resetn,
  input  logic       sck_rise,
  input  logic       sck_fall,
  input  logic       sel,
  input  logic       copi_s,
  input  logic [7:0] tx_byte,
  output logic [7:0] rx_byte,
  output logic       rx_strobe,
  output logic       byte_start,
  output logic       cipo,
  output logic       cipo_oe
);

  // Receive side
  logic [2:0] rx_cnt;
  logic [7:0] rx_shift;
  // Eight rising edges seen, waiting for the closing fall
  logic       rx_full;

  // Transmit side
  logic [7:0] tx_shift;
  // MSB of the current byte still comes straight from tx_byte
  logic       lead;
  logic       sel_q;

  // Falling edge after the eighth rise starts the next byte
  assign byte_start = sel & sck_fall & rx_full;

  always_ff @(posedge clk) begin
    if (resetn) begin
      rx_cnt    <= '0;
      rx_full   <= 1'b0;
      rx_strobe <= 1'b0;
      tx_shift  <= '0;
      lead      <= 1'b0;
      sel_q     <= 1'b0;
    end else begin
      sel_q     <= sel;
      rx_strobe <= byte_start;
      if (!sel) begin
        // Deselect aborts any byte in flight
        rx_cnt   <= '0;
        rx_full  <= 1'b0;
        tx_shift <= '0;
        lead     <= 1'b0;
      end else begin
        if (sck_rise) begin
          rx_cnt  <= rx_cnt + 3'd1;
          rx_full <= (rx_cnt == 3'd7);
        end
        if (!sel_q) begin
          // Select just began, first bit is presented before any clock
          lead <= 1'b1;
        end else if (byte_start) begin
          // Next byte's MSB goes out on this edge
          lead    <= 1'b1;
          rx_full <= 1'b0;
        end else if (sck_fall) begin
          if (lead) begin
            // First fall inside the byte, capture the rest of tx_byte
            tx_shift <= {tx_byte[6:0], 1'b0};
            lead     <= 1'b0;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  // Data path, MSB first in
  always_ff @(posedge clk) begin
    if (sel && sck_rise) begin
      rx_shift <= {rx_shift[6:0], copi_s};
    end
    if (byte_start) begin
      rx_byte <= rx_shift;
    end
  end

  assign cipo    = lead ? tx_byte[7] : tx_shift[7];
  assign cipo_oe = sel;

  // Completed bytes only while selected
  a_rx_in_sel: assert property (@(posedge clk) disable iff (resetn)
    rx_strobe |-> sel);

endmodule

`default_nettype wire

// ==== src/spi_frame_link.sv ====
// SPI frame assembler and reply server
`timescale 1ns/10ps
`default_nettype none

module spi_frame_link (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic                               sel,
  input  logic                               rx_strobe,
  input  logic                               byte_start,
  input  logic [7:0]                         rx_byte,
  input  logic [spi_reg_pkg::FRAME_BITS-1:0] reply_frame,
  output logic [7:0]                         tx_byte,
  output logic                               frame_strobe,
  output logic [spi_reg_pkg::FRAME_BITS-1:0] frame_rx
);

  import spi_reg_pkg::*;

  localparam int CNT_W = $clog2(FRAME_BYTES);

  // Byte position in the frame, advanced at each byte start
  logic [CNT_W-1:0]      byte_cnt;
  logic                  sel_q;
  // Reply held steady for the whole select period
  logic [FRAME_BITS-1:0] snap;
  // Receive word, bytes enter at the top
  logic [FRAME_BITS-1:0] rx_sr;

  always_ff @(posedge clk) begin
    if (resetn) begin
      byte_cnt     <= '0;
      sel_q        <= 1'b0;
      frame_strobe <= 1'b0;
    end else begin
      sel_q <= sel;
      // Count wraps to zero only after all eight bytes
      frame_strobe <= sel & rx_strobe & (byte_cnt == '0);
      if (!sel) begin
        // Short frame is dropped here
        byte_cnt <= '0;
      end else if (byte_start) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // Take the reply when select rises
    if (sel && !sel_q) begin
      snap <= reply_frame;
    end
    // First byte ends up in the low byte
    if (rx_strobe) begin
      rx_sr <= {rx_byte, rx_sr[FRAME_BITS-1:8]};
    end
  end

  assign frame_rx = rx_sr;

  // Reply goes out LSB byte first
  assign tx_byte = snap[{byte_cnt, 3'b000} +: 8];

  // Count held at zero outside a select period
  a_cnt_idle: assert property (@(posedge clk) disable iff (resetn)
    !sel |=> (byte_cnt == '0));

endmodule

`default_nettype wire

// ==== src/spi_reg_bank.sv ====
// SPI command decoder and register bank
`timescale 1ns/10ps
`default_nettype none

module spi_reg_bank #(
  parameter int REG_COUNT = 8
) (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic                               frame_strobe,
  input  logic [spi_reg_pkg::FRAME_BITS-1:0] frame_rx,
  output logic [spi_reg_pkg::FRAME_BITS-1:0] reply_frame,
  output logic [31:0]                        ctrl
);

  import spi_reg_pkg::*;

  localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

  // Received command and reply under construction
  spi_frame_u       cmd;
  spi_frame_u       reply;

  logic [31:0]      regs [REG_COUNT];
  logic [IDX_W-1:0] idx;

  // Decode
  logic             op_write;
  logic             op_read;
  logic             addr_ok;
  logic             cmd_err;
  logic             wr_en;
  // Register value as it stands after the command
  logic [31:0]      result;

  assign cmd.raw = frame_rx;

  assign op_write = (cmd.fields.opcode == OP_WRITE);
  assign op_read  = (cmd.fields.opcode == OP_READ);
  assign addr_ok  = (int'(cmd.fields.addr) < REG_COUNT);
  assign idx      = cmd.fields.addr[IDX_W-1:0];

  // Unknown opcode or address past the bank
  assign cmd_err = !(op_write || op_read) || !addr_ok;
  assign wr_en   = frame_strobe && op_write && addr_ok;

  // Write returns the new data, read the stored value
  assign result = cmd_err  ? 32'd0 :
                  op_write ? cmd.fields.data : regs[idx];

  always_comb begin
    reply.fields.opcode = cmd.fields.opcode;
    reply.fields.addr   = cmd.fields.addr;
    reply.fields.status = '0;
    reply.fields.status[STATUS_ERR_BIT] = cmd_err;
    reply.fields.pad    = '0;
    reply.fields.data   = result;
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      reply_frame <= '0;
    end else if (frame_strobe) begin
      if (wr_en) begin
        regs[idx] <= cmd.fields.data;
      end
      // Served during the next frame
      reply_frame <= reply.raw;
    end
  end

  // Register 0 doubles as the control word
  assign ctrl = regs[0];

  // Truncated write index stays inside the bank
  a_no_bad_write: assert property (@(posedge clk) disable iff (resetn)
    wr_en |-> (int'(idx) < REG_COUNT));

endmodule

`default_nettype wire

// ==== src/spi_reg_top.sv ====
// SPI register bank peripheral top
`timescale 1ns/10ps
`default_nettype none

module spi_reg_top #(
  parameter int REG_COUNT = 8
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        copi,
  output logic        cipo,
  output logic        cipo_oe,
  output logic [31:0] ctrl
);

  import spi_reg_pkg::*;

  // Synced pins and edges
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  sel;
  logic                  copi_s;

  // Byte level
  logic [7:0]            rx_byte;
  logic                  rx_strobe;
  logic                  byte_start;
  logic [7:0]            tx_byte;

  // Frame level
  logic                  frame_strobe;
  logic [FRAME_BITS-1:0] frame_rx;
  logic [FRAME_BITS-1:0] reply_frame;

  spi_pin_sync u_spi_pin_sync (
    .clk      (clk),
    .resetn   (resetn),
    .sck      (sck),
    .cs_n     (cs_n),
    .copi     (copi),
    .sck_rise (sck_rise),
    .sck_fall (sck_fall),
    .sel      (sel),
    .copi_s   (copi_s)
  );

  spi_byte_link u_spi_byte_link (
    .clk        (clk),
    .resetn     (resetn),
    .sck_rise   (sck_rise),
    .sck_fall   (sck_fall),
    .sel        (sel),
    .copi_s     (copi_s),
    .tx_byte    (tx_byte),
    .rx_byte    (rx_byte),
    .rx_strobe  (rx_strobe),
    .byte_start (byte_start),
    .cipo       (cipo),
    .cipo_oe    (cipo_oe)
  );

  spi_frame_link u_spi_frame_link (
    .clk          (clk),
    .resetn       (resetn),
    .sel          (sel),
    .rx_strobe    (rx_strobe),
    .byte_start   (byte_start),
    .rx_byte      (rx_byte),
    .reply_frame  (reply_frame),
    .tx_byte      (tx_byte),
    .frame_strobe (frame_strobe),
    .frame_rx     (frame_rx)
  );

  spi_reg_bank #(
    .REG_COUNT (REG_COUNT)
  ) u_spi_reg_bank (
    .clk          (clk),
    .resetn       (resetn),
    .frame_strobe (frame_strobe),
    .frame_rx     (frame_rx),
    .reply_frame  (reply_frame),
    .ctrl         (ctrl)
  );

endmodule

`default_nettype wire

// ==== verification/tb_spi_reg_tasks.svh ====
// SPI register bank directed tests
`ifndef TB_SPI_REG_TASKS_SVH
`define TB_SPI_REG_TASKS_SVH

  // Expected reply for a command, model updated as a side effect
  task automatic model_command(input logic [7:0] opcode, input logic [7:0] addr,
                               input logic [31:0] data, output logic [63:0] reply);
    logic        bad;
    logic [7:0]  status;
    logic [31:0] value;
    bad   = (opcode != OP_WRITE && opcode != OP_READ) || (addr >= REG_COUNT);
    value = 32'd0;
    // Bank of eight, low three address bits select
    if (!bad && opcode == OP_WRITE) begin
      model_regs[addr[2:0]] = data;
      value = data;
    end else if (!bad) begin
      value = model_regs[addr[2:0]];
    end
    status = 8'h00;
    status[STATUS_ERR_BIT] = bad;
    reply = {value, 8'h00, status, addr, opcode};
  endtask

  // One full frame; its reply answers the previous frame
  task automatic run_command(input logic [7:0] opcode, input logic [7:0] addr,
                             input logic [31:0] data);
    logic [63:0] got;
    logic [63:0] next_reply;
    spi_xfer_frame({data, 16'h0000, addr, opcode}, got);
    checks++;
    if (got !== exp_reply) begin
      errors++;
      $display("[ERROR] %0t: op %h addr %h got reply %h, expected %h",
               $time, opcode, addr, got, exp_reply);
    end
    model_command(opcode, addr, data, next_reply);
    exp_reply = next_reply;
  endtask

  task automatic check_ctrl(input string what);
    wait_cycles(SETTLE);
    @(negedge clk);
    checks++;
    if (ctrl !== model_regs[0]) begin
      errors++;
      $display("[ERROR] %0t: %s, ctrl %h, expected %h", $time, what, ctrl, model_regs[0]);
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    checks++;
    if (ctrl !== 32'd0 || cipo_oe !== 1'b0) begin
      errors++;
      $display("[ERROR] %0t: after reset ctrl %h cipo_oe %b", $time, ctrl, cipo_oe);
    end
    // Reply register starts cleared
    run_command(OP_READ, 8'd0, 32'd0);
  endtask

  task automatic test_write_read();
    logic [31:0] w;
    for (int a = 0; a < REG_COUNT; a++) begin
      rand_word(w);
      run_command(OP_WRITE, 8'(a), w);
    end
    // Data field of a read is ignored
    for (int a = 0; a < REG_COUNT; a++) begin
      rand_word(w);
      run_command(OP_READ, 8'(a), w);
    end
  endtask

  task automatic test_ctrl_output();
    logic [31:0] w;
    rand_word(w);
    run_command(OP_WRITE, 8'd0, w);
    check_ctrl("write to register 0");
    rand_word(w);
    run_command(OP_WRITE, 8'd3, w);
    check_ctrl("write to register 3");
  endtask

  task automatic test_bad_commands();
    logic [31:0] w;
    rand_word(w);
    run_command(8'h7f, 8'd1, w);
    rand_word(w);
    run_command(OP_WRITE, 8'd8, w);
    rand_word(w);
    run_command(OP_WRITE, 8'hff, w);
    run_command(OP_READ, 8'd200, 32'd0);
    check_ctrl("after rejected commands");
    // Every register keeps its value
    for (int a = 0; a < REG_COUNT; a++) begin
      run_command(OP_READ, 8'(a), 32'd0);
    end
  endtask

  task automatic test_aborted_frame();
    logic [31:0] w;
    logic [63:0] got;
    rand_word(w);
    // Write to register 0 cut off after three bytes
    spi_xfer_bits({w, 16'h0000, 8'd0, OP_WRITE}, 24, got);
    checks++;
    if (got[23:0] !== exp_reply[23:0]) begin
      errors++;
      $display("[ERROR] %0t: aborted frame reply %h, expected %h",
               $time, got[23:0], exp_reply[23:0]);
    end
    check_ctrl("after aborted frame");
    // Still answers the last complete frame, then shows register 0 untouched
    run_command(OP_READ, 8'd0, 32'd0);
    run_command(OP_READ, 8'd1, 32'd0);
  endtask

`endif

// ==== verification/tb_spi_reg_top.sv ====
// SPI register bank testbench
`timescale 1ns/10ps
`default_nettype none

module tb_spi_reg_top;

  import spi_reg_pkg::*;

  localparam int REG_COUNT   = 8;
  // SCK half-period in clock cycles
  localparam int HALF_SCK    = 10;
  localparam int IDLE_CYCLES = 4;
  // Margin before ctrl is read
  localparam int SETTLE      = 16;
  localparam int OE_TIMEOUT  = 20;

  logic        clk = 1'b0;
  logic        resetn;
  logic        sck;
  logic        cs_n;
  logic        copi;
  logic        cipo;
  logic        cipo_oe;
  logic [31:0] ctrl;

  // Reference register contents
  logic [31:0] model_regs [REG_COUNT];
  // Reply owed for the previous complete frame
  logic [63:0] exp_reply;
  logic [15:0] lfsr;
  int          checks;
  int          errors;
  int          timeouts;

  spi_reg_top #(
    .REG_COUNT (REG_COUNT)
  ) u_spi_reg_top (
    .clk     (clk),
    .resetn  (resetn),
    .sck     (sck),
    .cs_n    (cs_n),
    .copi    (copi),
    .cipo    (cipo),
    .cipo_oe (cipo_oe),
    .ctrl    (ctrl)
  );

  always #5 clk = ~clk;

  // Counts line, then the verdict
  task automatic finish_run();
    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  // Bit b on the wire, bytes LSB first and bits MSB first
  function automatic int bit_pos(input int b);
    return (b / 8) * 8 + 7 - (b % 8);
  endfunction

  task automatic wait_oe(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cipo_oe !== level && n < OE_TIMEOUT);
    if (cipo_oe !== level) begin
      $display("Timeout at %0t: cipo_oe never went %s", $time, level ? "high" : "low");
      timeouts++;
      finish_run();
    end
  endtask

  // Mode 0 bit-bang, returns what came back on cipo
  task automatic spi_xfer_bits(input logic [63:0] frame, input int nbits,
                               output logic [63:0] got);
    got = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    // First bit is on the line before any clock edge
    copi <= frame[bit_pos(0)];
    wait_oe(1'b1);
    for (int b = 0; b < nbits; b++) begin
      wait_cycles(HALF_SCK - 1);
      // Sample away from the clock edge
      @(negedge clk);
      got[bit_pos(b)] = cipo;
      @(posedge clk);
      sck <= 1'b1;
      wait_cycles(HALF_SCK);
      sck <= 1'b0;
      if (b + 1 < nbits) begin
        copi <= frame[bit_pos(b + 1)];
      end
    end
    // Let the last byte and frame strobes through before deselect
    wait_cycles(HALF_SCK);
    cs_n <= 1'b1;
    copi <= 1'b0;
    wait_oe(1'b0);
    wait_cycles(IDLE_CYCLES);
  endtask

  task automatic spi_xfer_frame(input logic [63:0] frame, output logic [63:0] got);
    spi_xfer_bits(frame, 64, got);
  endtask

  `include "tb_spi_reg_tasks.svh"

  initial begin
    resetn <= 1'b1;
    sck    <= 1'b0;
    cs_n   <= 1'b1;
    copi   <= 1'b0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    lfsr      = 16'd3;
    exp_reply = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    wait_cycles(8);
    resetn <= 1'b0;
    wait_cycles(4);
    test_reset_state();
    test_write_read();
    test_ctrl_output();
    test_bad_commands();
    test_aborted_frame();
    // Collect the reply of the final command
    run_command(OP_READ, 8'd0, 32'd0);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verification
src/spi_reg_pkg.sv
src/spi_pin_sync.sv
src/spi_byte_link.sv
src/spi_frame_link.sv
src/spi_reg_bank.sv
src/spi_reg_top.sv
verification/tb_spi_reg_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spi_reg_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
